//--- sim.f
+incdir+hdl
hdl/frame_req_pkg.sv
hdl/dram_pkg.sv
hdl/row_buffer.sv
hdl/line_assembler.sv
hdl/writeback_controller.sv
hdl/writeback_top.sv
sim/writeback_properties.sv
sim/writeback_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module writeback_tb -f sim.f
output=$(./obj_dir/Vwriteback_tb)
echo "$output"
if grep -qF '** PASS **' <<< "$output"; then
	exit 0
fi
exit 1

//--- sim/writeback_tb.sv
`default_nettype none

`include "wb_config.svh"

module writeback_tb;

	// covers 2048 fill cycles and about 60 lines of about 70 cycles each with a wide margin.
	localparam int MAX_CYCLES = 40000;

	logic clk = 1'b0;
	logic rst_n;
	logic fill_en;
	frame_req_pkg::buf_row_t fill_row;
	frame_req_pkg::buf_col_t fill_col;
	frame_req_pkg::byte_t fill_data;
	logic write;
	frame_req_pkg::dim_t width;
	frame_req_pkg::dim_t height;
	dram_pkg::dram_addr_t write_address;
	logic busy;
	logic request;
	logic rd_wr;
	dram_pkg::dram_addr_t address;
	dram_pkg::line_count_t request_size;
	logic fpu_ready;
	dram_pkg::cache_line_t write_data;
	logic dram_ready;
	logic request_done;

	dram_pkg::cache_line_t lines_got[$];
	dram_pkg::dram_addr_t line_addrs[$];
	dram_pkg::dram_addr_t req_addrs[$];
	dram_pkg::dram_addr_t req_base;
	int lines_left = 0;
	int done_delay = 0;
	int busy_falls = 0;
	int write_reqs = 0;
	logic busy_q = 1'b0;
	logic stalls = 1'b0;
	integer seed;
	int cycles = 0;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;

	writeback_top uut (.*);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles > MAX_CYCLES) begin
			$display("timeout: the run went past %0d cycles", MAX_CYCLES);
			$display("** FAIL **");
			$finish;
		end
	end

	// DRAM model that takes the lines and closes each row a few cycles after its last line.
	always @(posedge clk) begin
		request_done <= 1'b0;
		busy_q <= busy;
		if (busy_q && !busy) begin
			busy_falls++;
		end
		if (stalls) begin
			dram_ready <= ($random(seed) & 3) != 0; // ready about three cycles in four.
		end
		if (request) begin
			req_addrs.push_back(address);
			req_base = address;
			lines_left = int'(request_size);
			if (rd_wr) begin
				write_reqs++;
			end
		end
		if (fpu_ready) begin
			assert (dram_ready) else begin
				$display("fpu_ready was pulsed while dram_ready was low");
				errors++;
			end
			lines_got.push_back(write_data);
			line_addrs.push_back(req_base);
			lines_left--;
			if (lines_left == 0) begin
				done_delay = 3;
			end
		end else if (done_delay > 0) begin
			done_delay--;
			if (done_delay == 0) begin
				request_done <= 1'b1;
			end
		end
	end

	function automatic frame_req_pkg::byte_t pattern_byte(int row, int col);
		return frame_req_pkg::byte_t'((row * 31 + col) % 256);
	endfunction

	// first byte of the line lands in the top bits.
	function automatic dram_pkg::cache_line_t expected_line(int row, int idx);
		dram_pkg::cache_line_t l;
		for (int b = 0; b < `CL_BYTES; b++) begin
			l[(`CL_BYTES - 1 - b) * 8 +: 8] = pattern_byte(row, idx * `CL_BYTES + b);
		end
		return l;
	endfunction

	task automatic fill_buffer;
		for (int r = 0; r < `BUF_ROWS; r++) begin
			for (int c = 0; c < `BUF_COLS; c++) begin
				@(posedge clk);
				fill_en <= 1'b1;
				fill_row <= frame_req_pkg::buf_row_t'(r);
				fill_col <= frame_req_pkg::buf_col_t'(c);
				fill_data <= pattern_byte(r, c);
			end
		end
		@(posedge clk);
		fill_en <= 1'b0;
	endtask

	task automatic start_job(int w, int h, dram_pkg::dram_addr_t a);
		lines_got.delete();
		line_addrs.delete();
		req_addrs.delete();
		busy_falls = 0;
		write_reqs = 0;
		@(posedge clk);
		write <= 1'b1;
		width <= frame_req_pkg::dim_t'(w);
		height <= frame_req_pkg::dim_t'(h);
		write_address <= a;
		@(posedge clk);
		write <= 1'b0;
		@(posedge clk);
		assert (busy) else begin
			$display("busy did not rise after the write pulse");
			errors++;
		end
	endtask

	task automatic wait_idle;
		while (busy) begin
			@(posedge clk);
		end
		@(posedge clk); // lets the model count the falling edge.
	endtask

	task automatic check_job(string name, int w, int h, dram_pkg::dram_addr_t base);
		int n;
		int i;
		dram_pkg::dram_addr_t row_addr;
		n = (w + `CL_BYTES - 1) / `CL_BYTES;
		assert (busy_falls == 1) else begin
			$display("Fail %s: busy falls expected 1 actual %0d", name, busy_falls);
			errors++;
		end
		assert (write_reqs == h) else begin
			$display("Fail %s: requests with rd_wr expected %0d actual %0d",
				name, h, write_reqs);
			errors++;
		end
		assert (lines_got.size() == n * h && req_addrs.size() == h) else begin
			$display("Fail %s: lines expected %0d actual %0d, requests expected %0d actual %0d",
				name, n * h, lines_got.size(), h, req_addrs.size());
			errors++;
			return;
		end
		for (int r = 0; r < h; r++) begin
			row_addr = base + dram_pkg::dram_addr_t'(r * n * `CL_BYTES);
			assert (req_addrs[r] == row_addr) else begin
				$display("Fail %s: row %0d address expected %h actual %h",
					name, r, row_addr, req_addrs[r]);
				errors++;
			end
			for (int k = 0; k < n; k++) begin
				i = r * n + k;
				assert (lines_got[i] == expected_line(r, k)) else begin
					$display("Fail %s: line %0d expected %h actual %h",
						name, i, expected_line(r, k), lines_got[i]);
					errors++;
				end
				assert (line_addrs[i] == row_addr) else begin
					$display("Fail %s: line %0d request expected %h actual %h",
						name, i, row_addr, line_addrs[i]);
					errors++;
				end
			end
		end
	endtask

	task automatic report_test(string name, int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errors - errors_before);
			tests_failed++;
		end
	endtask

	task automatic single_line;
		int e;
		e = errors;
		assert (!busy && !request && !rd_wr && !fpu_ready &&
			address == '0 && write_data == '0) else begin
			$display("outputs were not idle after reset");
			errors++;
		end
		start_job(64, 1, 32'h0000_1000);
		wait_idle();
		check_job("single_line", 64, 1, 32'h0000_1000);
		report_test("single_line", e);
	endtask

	task automatic partial_width;
		int e;
		e = errors;
		start_job(130, 1, 32'h0000_2000);
		wait_idle();
		assert (request_size == 8'd3) else begin
			$display("Fail partial_width: request_size expected 3 actual %0d", request_size);
			errors++;
		end
		check_job("partial_width", 130, 1, 32'h0000_2000);
		report_test("partial_width", e);
	endtask

	task automatic four_rows;
		int e;
		e = errors;
		start_job(200, 4, 32'h0001_0000);
		wait_idle();
		check_job("four_rows", 200, 4, 32'h0001_0000);
		report_test("four_rows", e);
	endtask

	task automatic ready_stalls;
		int e;
		e = errors;
		stalls <= 1'b1;
		start_job(256, 8, 32'h0004_0000);
		wait_idle();
		stalls = 1'b0;
		dram_ready <= 1'b1;
		check_job("ready_stalls", 256, 8, 32'h0004_0000);
		report_test("ready_stalls", e);
	endtask

	task automatic write_while_busy;
		int e;
		e = errors;
		start_job(128, 2, 32'h0000_3000);
		repeat (20) @(posedge clk);
		write <= 1'b1;
		width <= 17'd64;
		height <= 17'd1;
		write_address <= 32'h0000_9000;
		@(posedge clk);
		write <= 1'b0;
		wait_idle();
		repeat (4) @(posedge clk);
		assert (!busy) else begin
			$display("busy rose again after the job ended");
			errors++;
		end
		check_job("write_while_busy", 128, 2, 32'h0000_3000);
		report_test("write_while_busy", e);
	endtask

	initial begin
		seed = 32'h8244;
		rst_n = 1'b0;
		fill_en = 1'b0;
		fill_row = '0;
		fill_col = '0;
		fill_data = '0;
		write = 1'b0;
		width = '0;
		height = '0;
		write_address = '0;
		dram_ready = 1'b1;
		request_done = 1'b0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		fill_buffer();
		single_line();
		partial_width();
		four_rows();
		ready_stalls();
		write_while_busy();
		$display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/writeback_properties.sv
`default_nettype none

module writeback_properties (
	input wire                        clk,
	input wire                        rst_n,
	input wire                        request,
	input wire                        rd_wr,
	input wire                        fpu_ready,
	input wire                        dram_ready,
	input wire                        waiting,
	input wire dram_pkg::cache_line_t write_data
);

	fpu_with_ready: assert property (@(posedge clk) disable iff (!rst_n)
		fpu_ready |-> dram_ready)
		else $error("fpu_ready high while dram_ready is low");

	request_is_write: assert property (@(posedge clk) disable iff (!rst_n)
		request |-> rd_wr)
		else $error("request without rd_wr");

	request_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		request |=> !request)
		else $error("request held for more than one cycle");

	// the packed line holds until DRAM takes it.
	data_holds: assert property (@(posedge clk) disable iff (!rst_n)
		waiting |=> $stable(write_data))
		else $error("write_data changed while waiting for dram_ready");

endmodule

bind writeback_controller writeback_properties props (
	.clk        (clk),
	.rst_n      (rst_n),
	.request    (request),
	.rd_wr      (rd_wr),
	.fpu_ready  (fpu_ready),
	.dram_ready (dram_ready),
	.waiting    (state == wait_ready),
	.write_data (write_data)
);

`default_nettype wire

//--- hdl/writeback_top.sv
`default_nettype none

module writeback_top (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          fill_en,
	input  wire frame_req_pkg::buf_row_t fill_row,
	input  wire frame_req_pkg::buf_col_t fill_col,
	input  wire frame_req_pkg::byte_t    fill_data,
	input  wire                          write,
	input  wire frame_req_pkg::dim_t     width,
	input  wire frame_req_pkg::dim_t     height,
	input  wire dram_pkg::dram_addr_t    write_address,
	output wire                          busy,
	output wire                          request,
	output wire                          rd_wr,
	output wire dram_pkg::dram_addr_t    address,
	output wire dram_pkg::line_count_t   request_size,
	output wire                          fpu_ready,
	output wire dram_pkg::cache_line_t   write_data,
	input  wire                          dram_ready,
	input  wire                          request_done
);

	wire frame_req_pkg::buf_row_t rd_row;
	wire frame_req_pkg::buf_col_t rd_col;
	wire frame_req_pkg::byte_t rd_data;
	wire dram_pkg::cache_line_t line;
	wire row_start;
	wire line_start;
	wire line_done;

	row_buffer buffer (
		.clk       (clk),
		.fill_en   (fill_en),
		.fill_row  (fill_row),
		.fill_col  (fill_col),
		.fill_data (fill_data),
		.rd_row    (rd_row),
		.rd_col    (rd_col),
		.rd_data   (rd_data)
	);

	line_assembler assembler (
		.clk        (clk),
		.rst_n      (rst_n),
		.row_start  (row_start),
		.line_start (line_start),
		.rd_data    (rd_data),
		.rd_col     (rd_col),
		.line       (line),
		.line_done  (line_done)
	);

	writeback_controller controller (
		.clk           (clk),
		.rst_n         (rst_n),
		.write         (write),
		.width         (width),
		.height        (height),
		.write_address (write_address),
		.busy          (busy),
		.rd_row        (rd_row),
		.row_start     (row_start),
		.line_start    (line_start),
		.line          (line),
		.line_done     (line_done),
		.request       (request),
		.rd_wr         (rd_wr),
		.address       (address),
		.request_size  (request_size),
		.dram_ready    (dram_ready),
		.fpu_ready     (fpu_ready),
		.write_data    (write_data),
		.request_done  (request_done)
	);

endmodule

`default_nettype wire

//--- hdl/writeback_controller.sv
`default_nettype none

`include "wb_config.svh"

module writeback_controller (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          write,
	input  wire frame_req_pkg::dim_t     width,
	input  wire frame_req_pkg::dim_t     height,
	input  wire dram_pkg::dram_addr_t    write_address,
	output logic                         busy,
	output frame_req_pkg::buf_row_t      rd_row,
	output logic                         row_start,
	output logic                         line_start,
	input  wire dram_pkg::cache_line_t   line,
	input  wire                          line_done,
	output logic                         request,
	output logic                         rd_wr,
	output dram_pkg::dram_addr_t         address,
	output dram_pkg::line_count_t        request_size,
	input  wire                          dram_ready,
	output logic                         fpu_ready,
	output dram_pkg::cache_line_t        write_data,
	input  wire                          request_done
);

	typedef enum logic [2:0] {
		idle,
		start_request,
		assemble,
		wait_ready,
		send_line,
		wait_done,
		next_row
	} wb_state_e;

	localparam int unsigned LINE_SHIFT = $clog2(`CL_BYTES);

	wb_state_e state;
	frame_req_pkg::dim_t height_q;
	frame_req_pkg::dim_t lines_needed;
	dram_pkg::line_count_t lines_sent;
	logic last_row;

	// width / 64, rounded up.
	assign lines_needed = (width >> LINE_SHIFT) +
		frame_req_pkg::dim_t'(|width[LINE_SHIFT-1:0]);

	assign last_row = (frame_req_pkg::dim_t'(rd_row) == height_q - 1'b1);

	// the line goes out in the same cycle that dram_ready is seen.
	assign fpu_ready = (state == wait_ready) && dram_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= idle;
			busy <= 1'b0;
			request <= 1'b0;
			rd_wr <= 1'b0;
			row_start <= 1'b0;
			line_start <= 1'b0;
			address <= '0;
			request_size <= '0;
			write_data <= '0;
			height_q <= '0;
			rd_row <= '0;
			lines_sent <= '0;
		end else begin
			request <= 1'b0;
			rd_wr <= 1'b0;
			row_start <= 1'b0;
			line_start <= 1'b0;
			case (state)
				idle: begin
					if (write) begin
						busy <= 1'b1;
						height_q <= height;
						request_size <= dram_pkg::line_count_t'(lines_needed);
						address <= write_address;
						rd_row <= '0;
						request <= 1'b1; // row 0 request.
						rd_wr <= 1'b1;
						row_start <= 1'b1;
						state <= start_request;
					end
				end
				start_request: begin
					lines_sent <= '0;
					line_start <= 1'b1;
					state <= assemble;
				end
				assemble: begin
					if (line_done) begin
						write_data <= line;
						state <= wait_ready;
					end
				end
				wait_ready: begin
					// hold write_data and the assembler until DRAM takes it.
					if (dram_ready) begin
						lines_sent <= lines_sent + 1'b1;
						state <= send_line;
					end
				end
				send_line: begin
					if (lines_sent == request_size) begin
						state <= wait_done;
					end else begin
						line_start <= 1'b1;
						state <= assemble;
					end
				end
				wait_done: begin
					if (request_done) begin
						if (last_row) begin
							busy <= 1'b0;
							state <= idle;
						end else begin
							state <= next_row;
						end
					end
				end
				next_row: begin
					// step by whole lines, not by width.
					address <= address + (dram_pkg::dram_addr_t'(request_size) << LINE_SHIFT);
					rd_row <= rd_row + 1'b1;
					request <= 1'b1;
					rd_wr <= 1'b1;
					row_start <= 1'b1;
					state <= start_request;
				end
				default: state <= idle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/line_assembler.sv
`default_nettype none

`include "wb_config.svh"

module line_assembler (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          row_start,
	input  wire                          line_start,
	input  wire frame_req_pkg::byte_t    rd_data,
	output frame_req_pkg::buf_col_t      rd_col,
	output dram_pkg::cache_line_t        line,
	output logic                         line_done
);

	typedef enum logic [1:0] {
		asm_idle,
		first_load,
		load,
		last_shift
	} asm_state_e;

	localparam int unsigned COUNT_WIDTH = $clog2(`CL_BYTES);
	localparam int unsigned LINE_BITS = $bits(dram_pkg::cache_line_t);
	localparam int unsigned BYTE_BITS = $bits(frame_req_pkg::byte_t);

	asm_state_e state;
	logic [COUNT_WIDTH-1:0] load_count;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= asm_idle;
			load_count <= '0;
			rd_col <= '0;
			line_done <= 1'b0;
		end else begin
			line_done <= 1'b0;
			case (state)
				asm_idle: begin
					if (row_start) begin
						rd_col <= '0; // next line starts at column 0.
					end
					if (line_start) begin
						state <= first_load;
					end
				end
				first_load: begin
					// address lead, nothing has arrived yet.
					rd_col <= rd_col + 1'b1;
					load_count <= COUNT_WIDTH'(1);
					state <= load;
				end
				load: begin
					rd_col <= rd_col + 1'b1;
					load_count <= load_count + 1'b1;
					if (load_count == COUNT_WIDTH'(`CL_BYTES - 1)) begin
						state <= last_shift; // all 64 addresses issued.
					end
				end
				last_shift: begin
					line_done <= 1'b1;
					state <= asm_idle;
				end
				default: state <= asm_idle;
			endcase
		end
	end

	// bytes trail the address by one cycle, so shifting starts in load
	// and the last byte goes in during last_shift.
	always_ff @(posedge clk) begin
		if (state == load || state == last_shift) begin
			line <= {line[LINE_BITS-BYTE_BITS-1:0], rd_data};
		end
	end

endmodule

`default_nettype wire

//--- hdl/row_buffer.sv
`default_nettype none

`include "wb_config.svh"

module row_buffer (
	input  wire                     clk,
	input  wire                     fill_en,
	input  wire frame_req_pkg::buf_row_t fill_row,
	input  wire frame_req_pkg::buf_col_t fill_col,
	input  wire frame_req_pkg::byte_t    fill_data,
	input  wire frame_req_pkg::buf_row_t rd_row,
	input  wire frame_req_pkg::buf_col_t rd_col,
	output frame_req_pkg::byte_t         rd_data
);

	frame_req_pkg::byte_t mem [`BUF_ROWS][`BUF_COLS];

	// fill port from the core.
	always_ff @(posedge clk) begin
		if (fill_en) begin
			mem[fill_row][fill_col] <= fill_data;
		end
	end

	// registered read, data one cycle after the address.
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_row][rd_col];
	end

endmodule

`default_nettype wire

//--- hdl/dram_pkg.sv
`default_nettype none

`include "wb_config.svh"

package dram_pkg;

	typedef logic [`ADDR_WIDTH-1:0] dram_addr_t; // byte address.

	// a full line, first byte in the top bits.
	typedef logic [`CL_BYTES*8-1:0] cache_line_t;

	typedef logic [7:0] line_count_t; // lines per request.

endpackage

`default_nettype wire

//--- hdl/frame_req_pkg.sv
`default_nettype none

`include "wb_config.svh"

package frame_req_pkg;

	// frame width in bytes or height in rows.
	typedef logic [16:0] dim_t;

	typedef logic [$clog2(`BUF_ROWS)-1:0] buf_row_t;
	typedef logic [$clog2(`BUF_COLS)-1:0] buf_col_t;

	typedef logic [7:0] byte_t; // one pixel.

endpackage

`default_nettype wire

//--- hdl/wb_config.svh
`ifndef WB_CONFIG_SVH
`define WB_CONFIG_SVH

// bytes in one DRAM cache line.
`define CL_BYTES 64

// byte columns per buffer row, four lines' worth.
`define BUF_COLS 256

// rows held in the row buffer.
`define BUF_ROWS 8

// DRAM byte address width.
`define ADDR_WIDTH 32

`endif
